// File: Bender.yml
package:
  name: umi_endpoint

sources:
  - logic/umi_pkg.sv
  - logic/mem_pkg.sv
  - logic/umi_decode.sv
  - logic/umi_atomic_alu.sv
  - logic/umi_mem_ctrl.sv
  - logic/umi_csr.sv
  - logic/umi_endpoint.sv
  - target: test
    files:
      - bench/tb_umi_endpoint.sv

// File: bench/tb_umi_endpoint.sv
`timescale 1ns/1ps

module tb_umi_endpoint;
   import umi_pkg::*;
   import mem_pkg::*;

   localparam int WR_ROUNDS   = 15; // write then read pairs
   localparam int ATOM_ROUNDS = 2;  // passes over all nine atomics
   localparam int INV_N       = 12; // random invalid commands
   localparam int DIS_N       = 8;  // requests sent while disabled
   localparam int TEST_CYCLES = 16 + WR_ROUNDS * 2 + ATOM_ROUNDS * 9 * 4 + INV_N * 2
                              + DIS_N * 2 + 80; // csr accesses and drains on top
   localparam int LIMIT_NS    = (TEST_CYCLES + 200) * 10;

   logic clk;
   logic rst;
   logic req_valid, csr_write, csr_read, resp_valid;
   logic [UMI_CW-1:0] req_cmd, resp_cmd;
   logic [MEM_AW-1:0] req_addr, resp_addr;
   logic [UMI_DW-1:0] req_data, resp_data, csr_wdata, csr_rdata;
   logic [CSR_AW-1:0] csr_addr;

   // reference model state
   logic [UMI_DW-1:0] ref_mem [MEM_DEPTH];
   logic              model_en;
   logic [UMI_DW-1:0] req_cnt_m, inv_cnt_m;
   int                cyc;
   int                exp_due_q [$];   // cycle in which the response gets registered
   logic [45:0]       exp_pay_q [$];   // {cmd, addr, data}
   logic              exp_valid, exp_csr_chk;
   logic [UMI_CW-1:0] exp_cmd;
   logic [MEM_AW-1:0] exp_addr;
   logic [UMI_DW-1:0] exp_data, exp_csr;
   int                resp_seen;       // responses the DUT gave
   int                resp_exp;        // responses the model asked for
   int                value_errs, other_errs;
   logic [15:0]       lfsr_state;

   logic [UMI_CW-1:0] write_cmds [5] = '{WRITE_POSTED, WRITE_SIGNAL, WRITE_ACK,
                                         WRITE_STREAM, WRITE_RESPONSE};
   logic [UMI_CW-1:0] atomic_cmds [9] = '{ATOMIC_SWAP, ATOMIC_ADD, ATOMIC_AND, ATOMIC_OR,
                                          ATOMIC_XOR, ATOMIC_MAX, ATOMIC_MIN, ATOMIC_MAXU,
                                          ATOMIC_MINU};

   umi_endpoint umi_endpoint_inst (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   // taps 16,14,13,11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state); // one step per bit
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic is_write(input logic [UMI_CW-1:0] c);
      return c inside {WRITE_POSTED, WRITE_SIGNAL, WRITE_ACK, WRITE_STREAM, WRITE_RESPONSE};
   endfunction

   // anything outside the opcode table, INVALID included
   function automatic logic is_invalid(input logic [UMI_CW-1:0] c);
      return !(is_write(c) || c inside {READ_REQUEST, READ_RESPONSE, ATOMIC_SWAP, ATOMIC_ADD,
               ATOMIC_AND, ATOMIC_OR, ATOMIC_XOR, ATOMIC_MAX, ATOMIC_MIN, ATOMIC_MAXU,
               ATOMIC_MINU});
   endfunction

   function automatic logic [UMI_DW-1:0] atomic_result(input logic [UMI_CW-1:0] c,
                                                        input logic [UMI_DW-1:0] w,
                                                        input logic [UMI_DW-1:0] op);
      case (c)
         ATOMIC_SWAP: return op;
         ATOMIC_ADD:  return w + op;
         ATOMIC_AND:  return w & op;
         ATOMIC_OR:   return w | op;
         ATOMIC_XOR:  return w ^ op;
         ATOMIC_MAX:  return ($signed(w) < $signed(op)) ? op : w;
         ATOMIC_MIN:  return ($signed(w) < $signed(op)) ? w : op;
         ATOMIC_MAXU: return (w < op) ? op : w;
         default:     return (w < op) ? w : op; // minu
      endcase
   endfunction

   // response lands on the edge after acceptance
   function automatic void expect_resp(input logic [UMI_CW-1:0] c, input logic [MEM_AW-1:0] a,
                                       input logic [UMI_DW-1:0] d);
      exp_due_q.push_back(cyc + 1);
      exp_pay_q.push_back({c, a, d});
   endfunction

   always @(posedge clk) begin : ref_model
      logic [UMI_DW-1:0] old_w;
      logic [UMI_DW-1:0] rd_val;
      logic [45:0]       pay;
      if (rst) begin
         model_en  = 1'b1; // enabled out of reset
         req_cnt_m = '0;
         inv_cnt_m = '0;
         cyc       = 0;
         for (int i = 0; i < MEM_DEPTH; i++) begin
            ref_mem[i] = '0;
         end
         exp_due_q.delete();
         exp_pay_q.delete();
         exp_valid   <= 1'b0;
         exp_csr_chk <= 1'b0;
      end else begin
         cyc++;
         if (resp_valid) resp_seen++; // level before this edge
         case (csr_addr) // register read sees state before this edge
            CSR_CTRL:    rd_val = {31'b0, model_en};
            CSR_REQ_CNT: rd_val = req_cnt_m;
            CSR_INV_CNT: rd_val = inv_cnt_m;
            default:     rd_val = '0;
         endcase
         exp_csr_chk <= csr_read;
         exp_csr     <= rd_val;
         if (req_valid && model_en) begin
            old_w = ref_mem[req_addr];
            req_cnt_m++; // invalid ones count too
            if (is_invalid(req_cmd)) begin
               inv_cnt_m++;
            end else if (req_cmd == READ_REQUEST) begin
               expect_resp(READ_RESPONSE, req_addr, old_w);
            end else if (is_write(req_cmd)) begin
               ref_mem[req_addr] = req_data;
               if (req_cmd == WRITE_ACK) begin
                  expect_resp(WRITE_RESPONSE, req_addr, '0);
               end
            end else if (req_cmd[3:0] == ATOMIC) begin
               ref_mem[req_addr] = atomic_result(req_cmd, old_w, req_data);
               expect_resp(READ_RESPONSE, req_addr, old_w); // old word back
            end
         end
         if (csr_write && csr_addr == CSR_CTRL) model_en = csr_wdata[0];
         if (csr_write && csr_addr == CSR_REQ_CNT) req_cnt_m = '0; // clear beats count
         if (csr_write && csr_addr == CSR_INV_CNT) inv_cnt_m = '0;
         if (exp_due_q.size() != 0 && exp_due_q[0] == cyc) begin
            pay = exp_pay_q.pop_front();
            void'(exp_due_q.pop_front());
            {exp_cmd, exp_addr, exp_data} <= pay;
            exp_valid <= 1'b1;
            resp_exp++;
         end else begin
            exp_valid <= 1'b0;
         end
      end
   end

   task automatic value_mismatch(input string name, input logic [UMI_DW-1:0] got,
                                 input logic [UMI_DW-1:0] exp);
      value_errs++;
      $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
   endtask

   assert property (@(posedge clk) disable iff (rst) resp_valid == exp_valid)
      else value_mismatch("resp_valid", $sampled(resp_valid), $sampled(exp_valid));
   assert property (@(posedge clk) disable iff (rst)
                    resp_valid && exp_valid |-> resp_cmd == exp_cmd)
      else value_mismatch("resp_cmd", $sampled(resp_cmd), $sampled(exp_cmd));
   assert property (@(posedge clk) disable iff (rst)
                    resp_valid && exp_valid |-> resp_addr == exp_addr)
      else value_mismatch("resp_addr", $sampled(resp_addr), $sampled(exp_addr));
   assert property (@(posedge clk) disable iff (rst)
                    resp_valid && exp_valid |-> resp_data == exp_data)
      else value_mismatch("resp_data", $sampled(resp_data), $sampled(exp_data));
   assert property (@(posedge clk) disable iff (rst) exp_csr_chk |-> csr_rdata == exp_csr)
      else value_mismatch("csr_rdata", $sampled(csr_rdata), $sampled(exp_csr));

   // every drive task owns one whole cycle, strobes it does not use go low
   task automatic send_req(input logic [UMI_CW-1:0] c, input logic [MEM_AW-1:0] a,
                           input logic [UMI_DW-1:0] d);
      @(negedge clk);
      {req_valid, req_cmd, req_addr, req_data} = {1'b1, c, a, d};
      {csr_write, csr_read} = 2'b00;
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      {req_valid, csr_write, csr_read} = 3'b000;
   endtask

   task automatic csr_write_reg(input logic [CSR_AW-1:0] a, input logic [UMI_DW-1:0] d);
      @(negedge clk);
      {req_valid, csr_write, csr_read, csr_addr, csr_wdata} = {3'b010, a, d};
   endtask

   task automatic csr_read_reg(input logic [CSR_AW-1:0] a);
      @(negedge clk);
      {req_valid, csr_write, csr_read, csr_addr} = {3'b001, a};
   endtask

   task automatic drain(); // until every expected response has come out
      idle_cycle();
      while (exp_due_q.size() != 0 || exp_valid) idle_cycle();
      idle_cycle();
   endtask

   initial begin : stimulus
      logic [31:0]       rnd;
      logic [MEM_AW-1:0] addr;
      logic [UMI_CW-1:0] cmd;
      logic [MEM_AW-1:0] dis_addrs [$];
      {rst, req_valid, csr_write, csr_read} = 4'b1000;
      {req_cmd, req_addr, req_data, csr_addr, csr_wdata} = '0;
      {resp_seen, resp_exp, value_errs, other_errs} = '0;
      lfsr_state = 16'd15; // seed
      repeat (16) @(negedge clk);
      rst = 1'b0;
      repeat (3) idle_cycle(); // quiet after reset
      csr_read_reg(CSR_CTRL);
      csr_read_reg(CSR_REQ_CNT);
      csr_read_reg(CSR_INV_CNT);
      for (int r = 0; r < WR_ROUNDS; r++) begin // each write kind, read straight after
         rnd = rand_bits(MEM_AW);
         addr = rnd[MEM_AW-1:0];
         send_req(write_cmds[r % 5], addr, rand_bits(UMI_DW));
         send_req(READ_REQUEST, addr, '0);
      end
      drain();
      for (int r = 0; r < ATOM_ROUNDS; r++) begin
         for (int k = 0; k < 9; k++) begin
            rnd = rand_bits(MEM_AW);
            addr = rnd[MEM_AW-1:0];
            send_req(WRITE_POSTED, addr, rand_bits(UMI_DW)); // seed word
            send_req(atomic_cmds[k], addr, rand_bits(UMI_DW));
            send_req(atomic_cmds[k], addr, rand_bits(UMI_DW)); // back to back, forwarded
            send_req(READ_REQUEST, addr, '0);
         end
      end
      drain();
      csr_write_reg(CSR_INV_CNT, '0);
      for (int i = 0; i < INV_N; i++) begin
         do begin
            rnd = rand_bits(UMI_CW);
            cmd = rnd[UMI_CW-1:0];
         end while (!is_invalid(cmd));
         rnd = rand_bits(MEM_AW);
         addr = rnd[MEM_AW-1:0];
         send_req(cmd, addr, rand_bits(UMI_DW));
         send_req(READ_REQUEST, addr, '0); // word must be untouched
      end
      drain();
      csr_read_reg(CSR_INV_CNT);
      csr_write_reg(CSR_CTRL, '0); // service off
      for (int i = 0; i < DIS_N; i++) begin
         rnd = rand_bits(MEM_AW);
         dis_addrs.push_back(rnd[MEM_AW-1:0]);
         send_req((i % 2) ? WRITE_ACK : ATOMIC_ADD, rnd[MEM_AW-1:0], rand_bits(UMI_DW));
      end
      repeat (2) idle_cycle();
      csr_read_reg(CSR_REQ_CNT);
      csr_read_reg(CSR_CTRL);
      csr_write_reg(CSR_CTRL, 32'h1);
      foreach (dis_addrs[i]) send_req(READ_REQUEST, dis_addrs[i], '0);
      drain();
      csr_read_reg(CSR_REQ_CNT);
      csr_read_reg(CSR_CTRL);
      repeat (2) idle_cycle();
      if (resp_seen != resp_exp) begin
         other_errs++;
         $display("DUT gave %0d responses where the model expected %0d", resp_seen, resp_exp);
      end
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      #(LIMIT_NS);
      $display("watchdog expired after %0d ns, the run did not complete", LIMIT_NS);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: logic/mem_pkg.sv
package mem_pkg;

   // memory geometry
   localparam int unsigned MEM_AW    = 6;          // word address
   localparam int unsigned MEM_DEPTH = 2**MEM_AW;  // 64 words

   // register map
   localparam int unsigned CSR_AW = 2;
   localparam logic [CSR_AW-1:0] CSR_CTRL    = 2'd0; // control word
   localparam logic [CSR_AW-1:0] CSR_REQ_CNT = 2'd1; // accepted requests
   localparam logic [CSR_AW-1:0] CSR_INV_CNT = 2'd2; // invalid commands

   // control word fields
   localparam int unsigned CTRL_EN_BIT = 0;    // service enable
   localparam logic        CTRL_EN_RST = 1'b1; // enabled out of reset

endpackage

// File: logic/umi_atomic_alu.sv
`timescale 1ns/1ps

module umi_atomic_alu (
   input  logic                       cmd_atomic_swap,
   input  logic                       cmd_atomic_add,
   input  logic                       cmd_atomic_and,
   input  logic                       cmd_atomic_or,
   input  logic                       cmd_atomic_xor,
   input  logic                       cmd_atomic_max,
   input  logic                       cmd_atomic_min,
   input  logic                       cmd_atomic_maxu,
   input  logic                       cmd_atomic_minu,
   input  logic [umi_pkg::UMI_DW-1:0] old_data, // word currently in memory
   input  logic [umi_pkg::UMI_DW-1:0] operand,  // request data
   output logic [umi_pkg::UMI_DW-1:0] new_data  // word to store back
);

   logic old_gt_s; // signed old > operand
   logic old_gt_u; // unsigned old > operand

   assign old_gt_s = ($signed(old_data) > $signed(operand));
   assign old_gt_u = (old_data > operand);

   // at most one strobe is high, decoder compares full opcode
   always_comb begin
      new_data = old_data; // no atomic, word unchanged
      if (cmd_atomic_swap) begin
         new_data = operand;
      end else if (cmd_atomic_add) begin
         new_data = old_data + operand; // wraps
      end else if (cmd_atomic_and) begin
         new_data = old_data & operand;
      end else if (cmd_atomic_or) begin
         new_data = old_data | operand;
      end else if (cmd_atomic_xor) begin
         new_data = old_data ^ operand;
      end else if (cmd_atomic_max) begin
         new_data = old_gt_s ? old_data : operand;
      end else if (cmd_atomic_min) begin
         new_data = old_gt_s ? operand : old_data;
      end else if (cmd_atomic_maxu) begin
         new_data = old_gt_u ? old_data : operand;
      end else if (cmd_atomic_minu) begin
         new_data = old_gt_u ? operand : old_data;
      end
   end

endmodule

// File: logic/umi_csr.sv
`timescale 1ns/1ps

module umi_csr (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       csr_write,
   input  logic                       csr_read,
   input  logic [mem_pkg::CSR_AW-1:0] csr_addr,
   input  logic [umi_pkg::UMI_DW-1:0] csr_wdata,
   output logic [umi_pkg::UMI_DW-1:0] csr_rdata, // valid cycle after csr_read
   input  logic                       req_accept,  // from memory controller
   input  logic                       cmd_invalid, // from decoder
   output logic                       enable       // gates request service
);
   import umi_pkg::*;
   import mem_pkg::*;

   logic [UMI_DW-1:0] req_cnt;   // accepted requests, invalid ones too
   logic [UMI_DW-1:0] inv_cnt;   // accepted invalid commands
   logic [UMI_DW-1:0] ctrl_word; // control register as read back
   logic              wr_ctrl;
   logic              wr_req;
   logic              wr_inv;

   assign wr_ctrl = csr_write & (csr_addr == CSR_CTRL);
   assign wr_req  = csr_write & (csr_addr == CSR_REQ_CNT);
   assign wr_inv  = csr_write & (csr_addr == CSR_INV_CNT);

   always_comb begin
      ctrl_word              = '0;
      ctrl_word[CTRL_EN_BIT] = enable;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         enable  <= CTRL_EN_RST;
         req_cnt <= '0;
         inv_cnt <= '0;
      end else begin
         if (wr_ctrl) begin
            enable <= csr_wdata[CTRL_EN_BIT];
         end
         if (wr_req) begin
            req_cnt <= '0; // any write value clears
         end else if (req_accept) begin
            req_cnt <= req_cnt + 1'b1; // wraps, no saturation
         end
         if (wr_inv) begin
            inv_cnt <= '0;
         end else if (req_accept && cmd_invalid) begin
            inv_cnt <= inv_cnt + 1'b1;
         end
      end
   end

   // registered read port
   always_ff @(posedge clk) begin
      if (csr_read) begin
         case (csr_addr)
            CSR_CTRL:    csr_rdata <= ctrl_word;
            CSR_REQ_CNT: csr_rdata <= req_cnt;
            CSR_INV_CNT: csr_rdata <= inv_cnt;
            default:     csr_rdata <= '0; // unmapped
         endcase
      end
   end

endmodule

// File: logic/umi_decode.sv
`timescale 1ns/1ps

module umi_decode (
   input  logic [umi_pkg::UMI_CW-1:0] command, // request command
   input  logic                       write,   // protocol parity only, not decoded
   output logic                       cmd_invalid,        // unknown or INVALID
   output logic                       cmd_read_request,
   output logic                       cmd_write_posted,
   output logic                       cmd_write_signal,   // write with eot
   output logic                       cmd_write_ack,      // write wanting a response
   output logic                       cmd_write_stream,
   output logic                       cmd_write_response,
   output logic                       cmd_atomic,         // any read-modify-write
   output logic                       cmd_atomic_swap,
   output logic                       cmd_atomic_add,
   output logic                       cmd_atomic_and,
   output logic                       cmd_atomic_or,
   output logic                       cmd_atomic_xor,
   output logic                       cmd_atomic_max,
   output logic                       cmd_atomic_min,
   output logic                       cmd_atomic_maxu,
   output logic                       cmd_atomic_minu
);
   import umi_pkg::*;

   logic cmd_known; // matches some defined opcode

   assign cmd_read_request   = (command == READ_REQUEST);
   assign cmd_atomic         = (command[3:0] == ATOMIC); // low nibble only

   // writes
   assign cmd_write_posted   = (command == WRITE_POSTED);
   assign cmd_write_signal   = (command == WRITE_SIGNAL);
   assign cmd_write_ack      = (command == WRITE_ACK);
   assign cmd_write_stream   = (command == WRITE_STREAM);
   assign cmd_write_response = (command == WRITE_RESPONSE);

   // atomics, full compare
   assign cmd_atomic_swap    = (command == ATOMIC_SWAP);
   assign cmd_atomic_add     = (command == ATOMIC_ADD);
   assign cmd_atomic_and     = (command == ATOMIC_AND);
   assign cmd_atomic_or      = (command == ATOMIC_OR);
   assign cmd_atomic_xor     = (command == ATOMIC_XOR);
   assign cmd_atomic_max     = (command == ATOMIC_MAX);
   assign cmd_atomic_min     = (command == ATOMIC_MIN);
   assign cmd_atomic_maxu    = (command == ATOMIC_MAXU);
   assign cmd_atomic_minu    = (command == ATOMIC_MINU);

   // READ_RESPONSE is a legal opcode, just nothing to do for it here
   assign cmd_known = cmd_read_request | (command == READ_RESPONSE)
                    | cmd_write_posted | cmd_write_signal | cmd_write_ack
                    | cmd_write_stream | cmd_write_response
                    | cmd_atomic_swap | cmd_atomic_add | cmd_atomic_and
                    | cmd_atomic_or | cmd_atomic_xor | cmd_atomic_max
                    | cmd_atomic_min | cmd_atomic_maxu | cmd_atomic_minu;

   assign cmd_invalid = (command == INVALID) | ~cmd_known; // e.g. 0xA4 lands here

endmodule

// File: logic/umi_endpoint.sv
`timescale 1ns/1ps

module umi_endpoint (
   input  logic                       clk,
   input  logic                       rst,
   // request port
   input  logic                       req_valid,
   input  logic [umi_pkg::UMI_CW-1:0] req_cmd,
   input  logic [mem_pkg::MEM_AW-1:0] req_addr,
   input  logic [umi_pkg::UMI_DW-1:0] req_data,
   // response port
   output logic                       resp_valid,
   output logic [umi_pkg::UMI_CW-1:0] resp_cmd,
   output logic [mem_pkg::MEM_AW-1:0] resp_addr,
   output logic [umi_pkg::UMI_DW-1:0] resp_data,
   // register port
   input  logic                       csr_write,
   input  logic                       csr_read,
   input  logic [mem_pkg::CSR_AW-1:0] csr_addr,
   input  logic [umi_pkg::UMI_DW-1:0] csr_wdata,
   output logic [umi_pkg::UMI_DW-1:0] csr_rdata
);
   import umi_pkg::*;

   // decoder outputs
   logic cmd_invalid, cmd_read_request, cmd_write_posted, cmd_write_signal;
   logic cmd_write_ack, cmd_write_stream, cmd_write_response, cmd_atomic;
   logic cmd_atomic_swap, cmd_atomic_add, cmd_atomic_and, cmd_atomic_or;
   logic cmd_atomic_xor, cmd_atomic_max, cmd_atomic_min;
   logic cmd_atomic_maxu, cmd_atomic_minu;
   // controller to alu, stage-1 op
   logic alu_swap, alu_add, alu_and, alu_or, alu_xor;
   logic alu_max, alu_min, alu_maxu, alu_minu;
   logic [UMI_DW-1:0] alu_old;
   logic [UMI_DW-1:0] alu_operand;
   logic [UMI_DW-1:0] alu_new;
   logic              req_accept;
   logic              enable;

   umi_decode umi_decode_inst (
      .command            (req_cmd),
      .write              (1'b0),    // requests carry no separate write bit
      .cmd_invalid        (cmd_invalid),
      .cmd_read_request   (cmd_read_request),
      .cmd_write_posted   (cmd_write_posted),
      .cmd_write_signal   (cmd_write_signal),
      .cmd_write_ack      (cmd_write_ack),
      .cmd_write_stream   (cmd_write_stream),
      .cmd_write_response (cmd_write_response),
      .cmd_atomic         (cmd_atomic),
      .cmd_atomic_swap    (cmd_atomic_swap),
      .cmd_atomic_add     (cmd_atomic_add),
      .cmd_atomic_and     (cmd_atomic_and),
      .cmd_atomic_or      (cmd_atomic_or),
      .cmd_atomic_xor     (cmd_atomic_xor),
      .cmd_atomic_max     (cmd_atomic_max),
      .cmd_atomic_min     (cmd_atomic_min),
      .cmd_atomic_maxu    (cmd_atomic_maxu),
      .cmd_atomic_minu    (cmd_atomic_minu)
   );

   umi_mem_ctrl umi_mem_ctrl_inst (.*); // names line up one to one

   umi_atomic_alu umi_atomic_alu_inst (
      .cmd_atomic_swap (alu_swap),
      .cmd_atomic_add  (alu_add),
      .cmd_atomic_and  (alu_and),
      .cmd_atomic_or   (alu_or),
      .cmd_atomic_xor  (alu_xor),
      .cmd_atomic_max  (alu_max),
      .cmd_atomic_min  (alu_min),
      .cmd_atomic_maxu (alu_maxu),
      .cmd_atomic_minu (alu_minu),
      .old_data        (alu_old),
      .operand         (alu_operand),
      .new_data        (alu_new)
   );

   umi_csr umi_csr_inst (
      .clk         (clk),
      .rst         (rst),
      .csr_write   (csr_write),
      .csr_read    (csr_read),
      .csr_addr    (csr_addr),
      .csr_wdata   (csr_wdata),
      .csr_rdata   (csr_rdata),
      .req_accept  (req_accept),
      .cmd_invalid (cmd_invalid),
      .enable      (enable)
   );

endmodule

// File: logic/umi_mem_ctrl.sv
`timescale 1ns/1ps

module umi_mem_ctrl (
   input  logic                       clk,
   input  logic                       rst,
   // request side
   input  logic                       req_valid,
   input  logic                       enable,     // from csr block
   input  logic [mem_pkg::MEM_AW-1:0] req_addr,
   input  logic [umi_pkg::UMI_DW-1:0] req_data,
   // decode strobes
   input  logic                       cmd_invalid,
   input  logic                       cmd_read_request,
   input  logic                       cmd_write_posted,
   input  logic                       cmd_write_signal,
   input  logic                       cmd_write_ack,
   input  logic                       cmd_write_stream,
   input  logic                       cmd_write_response,
   input  logic                       cmd_atomic,
   input  logic                       cmd_atomic_swap,
   input  logic                       cmd_atomic_add,
   input  logic                       cmd_atomic_and,
   input  logic                       cmd_atomic_or,
   input  logic                       cmd_atomic_xor,
   input  logic                       cmd_atomic_max,
   input  logic                       cmd_atomic_min,
   input  logic                       cmd_atomic_maxu,
   input  logic                       cmd_atomic_minu,
   // alu side, stage-1 operation
   output logic                       alu_swap,
   output logic                       alu_add,
   output logic                       alu_and,
   output logic                       alu_or,
   output logic                       alu_xor,
   output logic                       alu_max,
   output logic                       alu_min,
   output logic                       alu_maxu,
   output logic                       alu_minu,
   output logic [umi_pkg::UMI_DW-1:0] alu_old,
   output logic [umi_pkg::UMI_DW-1:0] alu_operand,
   input  logic [umi_pkg::UMI_DW-1:0] alu_new,
   output logic                       req_accept, // request taken this cycle
   // response side
   output logic                       resp_valid,
   output logic [umi_pkg::UMI_CW-1:0] resp_cmd,
   output logic [mem_pkg::MEM_AW-1:0] resp_addr,
   output logic [umi_pkg::UMI_DW-1:0] resp_data
);
   import umi_pkg::*;
   import mem_pkg::*;

   logic [UMI_DW-1:0] mem [MEM_DEPTH]; // word array

   // stage 1, request plus memory word
   logic              s1_valid;
   logic              s1_read;   // read request
   logic              s1_write;  // any of the five writes
   logic              s1_ack;    // write wants WRITE_RESPONSE
   logic              s1_atomic; // read-modify-write
   logic [8:0]        s1_amo;    // one-hot atomic kind
   logic [MEM_AW-1:0] s1_addr;
   logic [UMI_DW-1:0] s1_data;
   logic [UMI_DW-1:0] s1_rdata;  // old word, forwarded if needed

   logic              wr_en;     // stage-2 memory write
   logic [UMI_DW-1:0] wr_data;
   logic              fwd_hit;   // new read hits the word being written

   assign req_accept = req_valid & enable;

   assign wr_en   = s1_valid & (s1_write | s1_atomic);
   assign wr_data = s1_atomic ? alu_new : s1_data;
   assign fwd_hit = wr_en & (s1_addr == req_addr);

   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= req_accept;
      end
      s1_read   <= cmd_read_request;
      s1_write  <= cmd_write_posted | cmd_write_signal | cmd_write_ack
                 | cmd_write_stream | cmd_write_response;
      s1_ack    <= cmd_write_ack;
      s1_atomic <= cmd_atomic & ~cmd_invalid; // 0xA4 style codes are not atomics
      s1_amo    <= {cmd_atomic_minu, cmd_atomic_maxu, cmd_atomic_min, cmd_atomic_max,
                    cmd_atomic_xor, cmd_atomic_or, cmd_atomic_and, cmd_atomic_add,
                    cmd_atomic_swap};
      s1_addr   <= req_addr;
      s1_data   <= req_data;
      s1_rdata  <= fwd_hit ? wr_data : mem[req_addr]; // back-to-back same address
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] <= '0; // memory comes out of reset cleared
         end
      end else if (wr_en) begin
         mem[s1_addr] <= wr_data;
      end
   end

   assign {alu_minu, alu_maxu, alu_min, alu_max, alu_xor, alu_or, alu_and, alu_add,
           alu_swap} = s1_amo;
   assign alu_old     = s1_rdata;
   assign alu_operand = s1_data;

   // stage 2, response register
   always_ff @(posedge clk) begin
      if (rst) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= s1_valid & (s1_read | s1_atomic | s1_ack);
      end
      resp_cmd  <= s1_ack ? WRITE_RESPONSE : READ_RESPONSE;
      resp_addr <= s1_addr;
      resp_data <= s1_ack ? '0 : s1_rdata; // atomics return old word
   end

endmodule

// File: logic/umi_pkg.sv
package umi_pkg;

   localparam int unsigned UMI_DW = 32; // one data word
   localparam int unsigned UMI_CW = 8;  // one command word

   // basic request and response opcodes
   localparam logic [UMI_CW-1:0] INVALID        = 8'h00;
   localparam logic [UMI_CW-1:0] READ_REQUEST   = 8'h01;
   localparam logic [UMI_CW-1:0] READ_RESPONSE  = 8'h02;
   localparam logic [UMI_CW-1:0] WRITE_POSTED   = 8'h03;
   localparam logic [UMI_CW-1:0] WRITE_SIGNAL   = 8'h05; // write with eot signal
   localparam logic [UMI_CW-1:0] WRITE_ACK      = 8'h07; // acked write
   localparam logic [UMI_CW-1:0] WRITE_STREAM   = 8'h09;
   localparam logic [UMI_CW-1:0] WRITE_RESPONSE = 8'h0B;

   // low nibble common to every atomic
   localparam logic [3:0] ATOMIC = 4'h4;

   // atomics, high nibble picks the operation
   localparam logic [UMI_CW-1:0] ATOMIC_SWAP = 8'h04;
   localparam logic [UMI_CW-1:0] ATOMIC_ADD  = 8'h14;
   localparam logic [UMI_CW-1:0] ATOMIC_AND  = 8'h24;
   localparam logic [UMI_CW-1:0] ATOMIC_OR   = 8'h34;
   localparam logic [UMI_CW-1:0] ATOMIC_XOR  = 8'h44;
   localparam logic [UMI_CW-1:0] ATOMIC_MAX  = 8'h54; // signed
   localparam logic [UMI_CW-1:0] ATOMIC_MIN  = 8'h64; // signed
   localparam logic [UMI_CW-1:0] ATOMIC_MAXU = 8'h74;
   localparam logic [UMI_CW-1:0] ATOMIC_MINU = 8'h84;

endpackage

// File: src.f
logic/umi_pkg.sv
logic/mem_pkg.sv
logic/umi_decode.sv
logic/umi_atomic_alu.sv
logic/umi_mem_ctrl.sv
logic/umi_csr.sv
logic/umi_endpoint.sv
bench/tb_umi_endpoint.sv
